// ==== hw/dispatch_cfg.svh ====
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// register file sizes
`define NUM_SREGS 32
`define NUM_MREGS 16

// register index widths
`define SREG_W 5
`define MREG_W 4

`define INSTR_W 32
`define IMM_W 16

`endif

// ==== hw/dispatch_pkg.sv ====
`include "dispatch_cfg.svh"

package dispatch_pkg;

    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_MLOAD  = 7'b0000111,
        OP_MSTORE = 7'b0100111,
        OP_GEMM   = 7'b1110111
    } opcode_t;

    // scalar units, value doubles as fust_s slot index
    typedef enum logic [1:0] {
        FU_ALU, FU_LD_ST, FU_BRANCH, FU_S_NONE
    } fu_s_t;

    typedef enum logic [1:0] {
        FU_LD_ST_M, FU_GEMM, FU_M_NONE
    } fu_m_t;

    typedef enum logic [1:0] {
        M_NONE, M_LOAD, M_STORE
    } mem_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } branch_op_t;

    typedef struct packed {
        fu_s_t              fu_s;
        fu_m_t              fu_m;
        mem_t               s_mem_type;
        mem_t               m_mem_type;
        logic               reg_write;  // scalar destination write
        alu_op_t            alu_op;
        branch_op_t         branch_op;
        logic [`IMM_W-1:0]  imm;
    } decode_t;

    typedef struct packed {
        logic busy;
        logic tag;  // 0 alu/gemm, 1 load
    } status_t;

    typedef struct packed {
        logic               busy;
        logic [`SREG_W-1:0] rd;
        logic [`SREG_W-1:0] rs1;
        logic [`SREG_W-1:0] rs2;
        logic               t1;
        logic               t2;
    } fust_s_t;

    // matrix load/store, addresses come from scalar regs
    typedef struct packed {
        logic               busy;
        logic [`MREG_W-1:0] rd;
        logic [`SREG_W-1:0] rs1;
        logic [`SREG_W-1:0] rs2;
        logic               t1;
        logic               t2;
    } fust_m_t;

    typedef struct packed {
        logic               busy;
        logic [`MREG_W-1:0] rd;
        logic [`MREG_W-1:0] rs1;
        logic [`MREG_W-1:0] rs2;
        logic [`MREG_W-1:0] rs3;
        logic               t1;
        logic               t2;
        logic               t3;
    } fust_g_t;

    typedef struct packed {
        fust_s_t [2:0]      fust_s;
        fust_m_t            fust_m;
        fust_g_t            fust_g;
        alu_op_t            alu_op;
        branch_op_t         branch_op;
        logic [`IMM_W-1:0]  imm;
        mem_t               s_mem_type;
        mem_t               m_mem_type;
        logic               s_rw_en;
        logic [`SREG_W-1:0] s_rw;
        logic               m_rw_en;
        logic [`MREG_W-1:0] m_rw;
    } dispatch_t;

endpackage

// ==== hw/reg_status_if.sv ====
`timescale 1ns/1ns

interface reg_status_if #(
    parameter int NREGS = 32
);
    import dispatch_pkg::*;

    localparam int SEL_W = $clog2(NREGS);

    // set from dispatch
    logic             di_write;
    logic [SEL_W-1:0] di_sel;
    logic             di_tag;

    // clear from writeback commit
    logic             wb_write;
    logic [SEL_W-1:0] wb_sel;

    status_t [NREGS-1:0] status;

    modport disp (
        output di_write, di_sel, di_tag, wb_write, wb_sel,
        input  status
    );

    modport tbl (
        input  di_write, di_sel, di_tag, wb_write, wb_sel,
        output status
    );

endinterface

// ==== hw/decoder.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module decoder (
    input  logic [`INSTR_W-1:0] instr,
    output dispatch_pkg::decode_t dec
);
    import dispatch_pkg::*;

    opcode_t op;

    assign op = opcode_t'(instr[6:0]);

    always_comb begin
        // unknown opcodes fall through as a nop
        dec.fu_s       = FU_S_NONE;
        dec.fu_m       = FU_M_NONE;
        dec.s_mem_type = M_NONE;
        dec.m_mem_type = M_NONE;
        dec.reg_write  = 1'b0;
        dec.alu_op     = alu_op_t'(instr[14:12]);     // funct3
        dec.branch_op  = branch_op_t'(instr[14:12]);
        dec.imm        = instr[`IMM_W-1:0];

        case (op)
            OP_ALU: begin
                dec.fu_s      = FU_ALU;
                dec.reg_write = 1'b1;
            end
            OP_LOAD: begin
                dec.fu_s       = FU_LD_ST;
                dec.s_mem_type = M_LOAD;
                dec.reg_write  = 1'b1;
            end
            OP_STORE: begin
                dec.fu_s       = FU_LD_ST;
                dec.s_mem_type = M_STORE;
            end
            OP_BRANCH: begin
                dec.fu_s = FU_BRANCH;
            end
            OP_MLOAD: begin
                dec.fu_m       = FU_LD_ST_M;
                dec.m_mem_type = M_LOAD;   // writes a matrix reg
            end
            OP_MSTORE: begin
                dec.fu_m       = FU_LD_ST_M;
                dec.m_mem_type = M_STORE;
            end
            OP_GEMM: begin
                dec.fu_m = FU_GEMM;
            end
            default: begin
                dec.fu_s = FU_S_NONE;
                dec.fu_m = FU_M_NONE;
            end
        endcase
    end

endmodule

// ==== hw/reg_status_table.sv ====
`timescale 1ns/1ns

module reg_status_table #(
    parameter int NREGS = 32
) (
    input logic CLK,
    input logic nRST,
    reg_status_if.tbl rs
);
    import dispatch_pkg::*;

    status_t [NREGS-1:0] entries;

    assign rs.status = entries;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entries <= '0;
        end else begin
            if (rs.wb_write) begin
                entries[rs.wb_sel] <= '0;
            end
            // set comes last so it wins over a clear to the same reg
            if (rs.di_write) begin
                entries[rs.di_sel].busy <= 1'b1;
                entries[rs.di_sel].tag  <= rs.di_tag;
            end
        end
    end

    // dispatch must have caught the WAW before setting
    a_no_waw_set: assert property (
        @(posedge CLK) disable iff (!nRST)
        rs.di_write |-> !entries[rs.di_sel].busy
    );

endmodule

// ==== hw/dispatch_stage.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_stage (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [`INSTR_W-1:0]    instr,
    input  logic                   ihit,
    input  logic                   freeze,
    input  logic                   flush,
    input  logic [2:0]             fu_busy_s,
    input  logic [1:0]             fu_busy_m,
    input  logic                   srw_en,
    input  logic [`SREG_W-1:0]     srw,
    input  logic                   mrw_en,
    input  logic [`MREG_W-1:0]     mrw,
    output dispatch_pkg::dispatch_t out,
    output logic                   stall,
    reg_status_if.disp             srs,
    reg_status_if.disp             mrs
);
    import dispatch_pkg::*;

    decode_t dec;
    dispatch_t rec;

    logic [`SREG_W-1:0] s_rd, s_rs1, s_rs2;
    logic [`MREG_W-1:0] m_rd, m_rs1, m_rs2, m_rs3;

    logic s_busy, m_busy, waw, hazard;
    logic m_write;
    logic flush_hit, advance;

    decoder u_dec (
        .instr (instr),
        .dec   (dec)
    );

    assign s_rd  = instr[11:7];
    assign s_rs1 = instr[19:15];
    assign s_rs2 = instr[24:20];
    assign m_rd  = instr[31:28];
    assign m_rs1 = instr[27:24];
    assign m_rs2 = instr[23:20];
    assign m_rs3 = instr[19:16];

    assign m_write = (dec.m_mem_type == M_LOAD) || (dec.fu_m == FU_GEMM);

    // structural hazards
    assign s_busy = (dec.fu_s != FU_S_NONE) && fu_busy_s[dec.fu_s];
    assign m_busy = (dec.fu_m != FU_M_NONE) && fu_busy_m[dec.fu_m[0]];

    always_comb begin
        if (m_write) begin
            waw = mrs.status[m_rd].busy;
        end else if (dec.reg_write) begin
            waw = srs.status[s_rd].busy;
        end else begin
            waw = 1'b0;
        end
    end

    assign hazard    = s_busy | m_busy | waw;
    assign stall     = hazard;
    assign flush_hit = flush & ihit;
    assign advance   = ihit & ~flush_hit & ~freeze & ~hazard;

    // table sets only on a real advance
    assign srs.di_write = advance & dec.reg_write;
    assign srs.di_sel   = s_rd;
    assign srs.di_tag   = (dec.s_mem_type == M_LOAD);
    assign mrs.di_write = advance & m_write;
    assign mrs.di_sel   = m_rd;
    assign mrs.di_tag   = (dec.m_mem_type == M_LOAD);

    // commits are never held back
    assign srs.wb_write = srw_en;
    assign srs.wb_sel   = srw;
    assign mrs.wb_write = mrw_en;
    assign mrs.wb_sel   = mrw;

    always_comb begin
        rec = '0;

        if (dec.fu_s != FU_S_NONE) begin
            rec.fust_s[dec.fu_s].busy = 1'b1;
            rec.fust_s[dec.fu_s].rd   = s_rd;
            rec.fust_s[dec.fu_s].rs1  = s_rs1;
            rec.fust_s[dec.fu_s].rs2  = s_rs2;
            rec.fust_s[dec.fu_s].t1   = srs.status[s_rs1].tag;
            rec.fust_s[dec.fu_s].t2   = srs.status[s_rs2].tag;
        end

        if (dec.fu_m == FU_LD_ST_M) begin
            rec.fust_m.busy = 1'b1;
            rec.fust_m.rd   = m_rd;
            rec.fust_m.rs1  = s_rs1;   // scalar address regs
            rec.fust_m.rs2  = s_rs2;
            rec.fust_m.t1   = srs.status[s_rs1].tag;
            rec.fust_m.t2   = srs.status[s_rs2].tag;
        end else if (dec.fu_m == FU_GEMM) begin
            rec.fust_g.busy = 1'b1;
            rec.fust_g.rd   = m_rd;
            rec.fust_g.rs1  = m_rs1;
            rec.fust_g.rs2  = m_rs2;
            rec.fust_g.rs3  = m_rs3;
            rec.fust_g.t1   = mrs.status[m_rs1].tag;
            rec.fust_g.t2   = mrs.status[m_rs2].tag;
            rec.fust_g.t3   = mrs.status[m_rs3].tag;
        end

        rec.alu_op     = dec.alu_op;
        rec.branch_op  = dec.branch_op;
        rec.imm        = dec.imm;
        rec.s_mem_type = dec.s_mem_type;
        rec.m_mem_type = dec.m_mem_type;

        rec.s_rw_en = dec.reg_write;
        rec.s_rw    = s_rd;
        rec.m_rw_en = m_write;
        rec.m_rw    = m_rd;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (flush_hit) begin
            out <= '0;
        end else if (freeze || hazard) begin
            out <= out;
        end else if (ihit) begin
            out <= rec;
        end
    end

    // at most one unit slot per record, scalar or matrix
    a_one_slot: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0({out.fust_s[2].busy, out.fust_s[1].busy, out.fust_s[0].busy,
                  out.fust_m.busy, out.fust_g.busy})
    );

endmodule

// ==== hw/dispatch_top.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_top (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic [`INSTR_W-1:0]     instr,
    input  logic                    ihit,
    input  logic                    freeze,
    input  logic                    flush,
    input  logic [2:0]              fu_busy_s,
    input  logic [1:0]              fu_busy_m,
    input  logic                    srw_en,
    input  logic [`SREG_W-1:0]      srw,
    input  logic                    mrw_en,
    input  logic [`MREG_W-1:0]      mrw,
    output dispatch_pkg::dispatch_t out,
    output logic                    stall
);
    import dispatch_pkg::*;

    reg_status_if #(.NREGS(`NUM_SREGS)) srsif ();
    reg_status_if #(.NREGS(`NUM_MREGS)) mrsif ();

    dispatch_stage u_stage (
        .CLK       (CLK),
        .nRST      (nRST),
        .instr     (instr),
        .ihit      (ihit),
        .freeze    (freeze),
        .flush     (flush),
        .fu_busy_s (fu_busy_s),
        .fu_busy_m (fu_busy_m),
        .srw_en    (srw_en),
        .srw       (srw),
        .mrw_en    (mrw_en),
        .mrw       (mrw),
        .out       (out),
        .stall     (stall),
        .srs       (srsif.disp),
        .mrs       (mrsif.disp)
    );

    reg_status_table #(.NREGS(`NUM_SREGS)) u_srst (  // scalar regs
        .CLK  (CLK),
        .nRST (nRST),
        .rs   (srsif.tbl)
    );

    reg_status_table #(.NREGS(`NUM_MREGS)) u_mrst (  // matrix regs
        .CLK  (CLK),
        .nRST (nRST),
        .rs   (mrsif.tbl)
    );

endmodule

// ==== test/dispatch_ref.svh ====
`ifndef DISPATCH_REF_SVH
`define DISPATCH_REF_SVH

// shadow of both status tables, state after the coming edge
status_t s_shadow [`NUM_SREGS];
status_t m_shadow [`NUM_MREGS];

task automatic shadow_reset;
    s_shadow = '{default: '0};
    m_shadow = '{default: '0};
endtask

// expected record for an instruction that is accepted now
function automatic dispatch_t ref_decode(input logic [`INSTR_W-1:0] ins);
    dispatch_t r;
    logic [6:0] op;
    logic [`SREG_W-1:0] rd, a, b;
    logic [`MREG_W-1:0] mrd, ma, mb, mc;
    logic has_slot;
    fu_s_t slot;

    op  = ins[6:0];
    rd  = ins[11:7];
    a   = ins[19:15];
    b   = ins[24:20];
    mrd = ins[31:28];
    ma  = ins[27:24];
    mb  = ins[23:20];
    mc  = ins[19:16];

    r = '0;
    has_slot = 1'b1;
    slot = FU_ALU;
    r.alu_op    = alu_op_t'(ins[14:12]);
    r.branch_op = branch_op_t'(ins[14:12]);
    r.imm       = ins[15:0];
    r.s_rw      = rd;
    r.m_rw      = mrd;

    case (op)
        OP_ALU: begin
            r.s_rw_en = 1'b1;
        end
        OP_LOAD: begin
            slot = FU_LD_ST;
            r.s_mem_type = M_LOAD;
            r.s_rw_en = 1'b1;
        end
        OP_STORE: begin
            slot = FU_LD_ST;
            r.s_mem_type = M_STORE;
        end
        OP_BRANCH: begin
            slot = FU_BRANCH;
        end
        OP_MLOAD: begin
            has_slot = 1'b0;
            r.m_mem_type = M_LOAD;
            r.m_rw_en = 1'b1;
            r.fust_m = '{busy: 1'b1, rd: mrd, rs1: a, rs2: b,
                         t1: s_shadow[a].tag, t2: s_shadow[b].tag};
        end
        OP_MSTORE: begin
            has_slot = 1'b0;
            r.m_mem_type = M_STORE;
            r.fust_m = '{busy: 1'b1, rd: mrd, rs1: a, rs2: b,
                         t1: s_shadow[a].tag, t2: s_shadow[b].tag};
        end
        OP_GEMM: begin
            has_slot = 1'b0;
            r.m_rw_en = 1'b1;
            r.fust_g = '{busy: 1'b1, rd: mrd, rs1: ma, rs2: mb, rs3: mc,
                         t1: m_shadow[ma].tag, t2: m_shadow[mb].tag,
                         t3: m_shadow[mc].tag};
        end
        default: begin
            has_slot = 1'b0;  // nop record
        end
    endcase

    if (has_slot) begin
        r.fust_s[slot] = '{busy: 1'b1, rd: rd, rs1: a, rs2: b,
                           t1: s_shadow[a].tag, t2: s_shadow[b].tag};
    end
    return r;
endfunction

function automatic logic ref_hazard(
    input logic [`INSTR_W-1:0] ins,
    input logic [2:0]          bs,
    input logic [1:0]          bm
);
    case (ins[6:0])
        OP_ALU:    return bs[0] | s_shadow[ins[11:7]].busy;
        OP_LOAD:   return bs[1] | s_shadow[ins[11:7]].busy;
        OP_STORE:  return bs[1];
        OP_BRANCH: return bs[2];
        OP_MLOAD:  return bm[0] | m_shadow[ins[31:28]].busy;
        OP_MSTORE: return bm[0];
        OP_GEMM:   return bm[1] | m_shadow[ins[31:28]].busy;
        default:   return 1'b0;
    endcase
endfunction

task automatic shadow_update(
    input logic [`INSTR_W-1:0] ins,
    input logic                go,
    input logic                sc_en,
    input logic [`SREG_W-1:0]  sc,
    input logic                mc_en,
    input logic [`MREG_W-1:0]  mc
);
    logic [6:0] op;

    op = ins[6:0];
    if (sc_en) begin
        s_shadow[sc] = '0;
    end
    if (mc_en) begin
        m_shadow[mc] = '0;
    end
    // a set on the same edge wins over the clear
    if (go && (op == OP_ALU || op == OP_LOAD)) begin
        s_shadow[ins[11:7]].busy = 1'b1;
        s_shadow[ins[11:7]].tag  = (op == OP_LOAD);
    end
    if (go && (op == OP_MLOAD || op == OP_GEMM)) begin
        m_shadow[ins[31:28]].busy = 1'b1;
        m_shadow[ins[31:28]].tag  = (op == OP_MLOAD);
    end
endtask

`endif

// ==== test/dispatch_tb.sv ====
`timescale 1ns/1ns
`include "dispatch_cfg.svh"

module dispatch_tb;
    import dispatch_pkg::*;

    localparam int RAND_CYCLES     = 2000;
    localparam int DIRECTED_CYCLES = 60;  // reset plus directed tests
    localparam int MAX_CYCLES      = DIRECTED_CYCLES + RAND_CYCLES + 100;

    logic                CLK;
    logic                nRST;
    logic [`INSTR_W-1:0] instr;
    logic                ihit;
    logic                freeze;
    logic                flush;
    logic [2:0]          fu_busy_s;
    logic [1:0]          fu_busy_m;
    logic                srw_en;
    logic [`SREG_W-1:0]  srw;
    logic                mrw_en;
    logic [`MREG_W-1:0]  mrw;
    dispatch_t           out;
    logic                stall;

    int cycle_count = 0;
    logic [6:0] op_list [8] = '{OP_ALU, OP_LOAD, OP_STORE, OP_BRANCH,
                                OP_MLOAD, OP_MSTORE, OP_GEMM, 7'h7f};

    `include "dispatch_ref.svh"

    dispatch_top UUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .instr     (instr),
        .ihit      (ihit),
        .freeze    (freeze),
        .flush     (flush),
        .fu_busy_s (fu_busy_s),
        .fu_busy_m (fu_busy_m),
        .srw_en    (srw_en),
        .srw       (srw),
        .mrw_en    (mrw_en),
        .mrw       (mrw),
        .out       (out),
        .stall     (stall)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic abort_run;
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_record(input dispatch_t exp, input dispatch_t act);
        if (act !== exp) begin
            $display("Error: out expected %h, got %h", exp, act);
            abort_run();
        end
    endtask

    task automatic check_stall(input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: stall expected %h, got %h", exp, act);
            abort_run();
        end
    endtask

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    function automatic logic [`INSTR_W-1:0] enc_scalar(
        input logic [6:0]         op,
        input logic [`SREG_W-1:0] rd,
        input logic [`SREG_W-1:0] rs1,
        input logic [`SREG_W-1:0] rs2,
        input logic [2:0]         f3
    );
        return {7'h15, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [`INSTR_W-1:0] enc_matrix(
        input logic [6:0]         op,
        input logic [`MREG_W-1:0] rd,
        input logic [`MREG_W-1:0] rs1,
        input logic [`MREG_W-1:0] rs2,
        input logic [`MREG_W-1:0] rs3
    );
        return {rd, rs1, rs2, rs3, 9'h0a5, op};
    endfunction

    task automatic apply_inputs(
        input logic [`INSTR_W-1:0] ins,
        input logic                hit,
        input logic                frz,
        input logic                fl,
        input logic [2:0]          bs,
        input logic [1:0]          bm,
        input logic                sc_en,
        input logic [`SREG_W-1:0]  sc,
        input logic                mc_en,
        input logic [`MREG_W-1:0]  mc
    );
        instr     <= ins;
        ihit      <= hit;
        freeze    <= frz;
        flush     <= fl;
        fu_busy_s <= bs;
        fu_busy_m <= bm;
        srw_en    <= sc_en;
        srw       <= sc;
        mrw_en    <= mc_en;
        mrw       <= mc;
    endtask

    task automatic drive_cycle(
        input logic [`INSTR_W-1:0] ins,
        input logic                hit,
        input logic                frz,
        input logic                fl,
        input logic [2:0]          bs,
        input logic [1:0]          bm,
        input logic                sc_en,
        input logic [`SREG_W-1:0]  sc,
        input logic                mc_en,
        input logic [`MREG_W-1:0]  mc
    );
        @(posedge CLK);
        apply_inputs(ins, hit, frz, fl, bs, bm, sc_en, sc, mc_en, mc);
    endtask

    task automatic run_instr(input logic [`INSTR_W-1:0] ins);
        drive_cycle(ins, 1'b1, 1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic commit(
        input logic               sc_en,
        input logic [`SREG_W-1:0] sc,
        input logic               mc_en,
        input logic [`MREG_W-1:0] mc
    );
        drive_cycle('0, 1'b0, 1'b0, 1'b0, '0, '0, sc_en, sc, mc_en, mc);
    endtask

    task automatic confirm_stall(input logic exp);
        @(negedge CLK);
        check_stall(exp, stall);
    endtask

    // commits only target registers the shadow holds busy
    task automatic random_cycle;
        logic [`INSTR_W-1:0] ins;
        int s_q [$];
        int m_q [$];
        int i;
        logic sc_en;
        logic mc_en;
        logic [`SREG_W-1:0] sc;
        logic [`MREG_W-1:0] mc;

        @(posedge CLK);
        ins = $urandom;
        ins[6:0] = op_list[3'($urandom_range(7))];
        for (i = 0; i < `NUM_SREGS; i++) begin
            if (s_shadow[i].busy) begin
                s_q.push_back(i);
            end
        end
        for (i = 0; i < `NUM_MREGS; i++) begin
            if (m_shadow[i].busy) begin
                m_q.push_back(i);
            end
        end
        sc_en = 1'b0;
        sc = '0;
        mc_en = 1'b0;
        mc = '0;
        if (s_q.size() > 0 && $urandom_range(99) < 40) begin
            sc_en = 1'b1;
            sc = s_q[$urandom_range(s_q.size() - 1)][`SREG_W-1:0];
        end
        if (m_q.size() > 0 && $urandom_range(99) < 40) begin
            mc_en = 1'b1;
            mc = m_q[$urandom_range(m_q.size() - 1)][`MREG_W-1:0];
        end
        apply_inputs(ins, $urandom_range(99) < 80, $urandom_range(99) < 8,
                     $urandom_range(99) < 5, 3'($urandom & $urandom),
                     2'($urandom & $urandom), sc_en, sc, mc_en, mc);
    endtask

    // inputs and outputs are settled at the falling edge
    initial begin : compare
        dispatch_t exp_out;
        logic exp_stall;
        logic go;

        exp_out = '0;
        shadow_reset();
        @(posedge nRST);
        forever begin
            @(negedge CLK);
            check_record(exp_out, out);
            exp_stall = ref_hazard(instr, fu_busy_s, fu_busy_m);
            check_stall(exp_stall, stall);
            go = ihit && !flush && !freeze && !exp_stall;
            if (ihit && flush) begin
                exp_out = '0;
            end else if (go) begin
                exp_out = ref_decode(instr);
            end
            shadow_update(instr, go, srw_en, srw, mrw_en, mrw);
        end
    end

    initial begin
        void'($urandom(63));
        instr     = '0;
        ihit      = 1'b0;
        freeze    = 1'b0;
        flush     = 1'b0;
        fu_busy_s = '0;
        fu_busy_m = '0;
        srw_en    = 1'b0;
        srw       = '0;
        mrw_en    = 1'b0;
        mrw       = '0;
        nRST      = 1'b0;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;

        // one of each opcode into idle units
        run_instr(enc_scalar(OP_ALU, 5'd1, 5'd3, 5'd4, 3'd2));
        run_instr(enc_scalar(OP_LOAD, 5'd2, 5'd1, 5'd0, 3'd0));
        run_instr(enc_scalar(OP_STORE, 5'd10, 5'd2, 5'd1, 3'd3));  // load tag on rs1
        run_instr(enc_scalar(OP_BRANCH, 5'd0, 5'd2, 5'd5, 3'd1));
        run_instr(enc_matrix(OP_MLOAD, 4'd1, 4'd0, 4'd1, 4'd1));
        run_instr(enc_matrix(OP_MSTORE, 4'd3, 4'd0, 4'd1, 4'd1));
        run_instr(enc_matrix(OP_GEMM, 4'd2, 4'd1, 4'd3, 4'd1));
        run_instr({25'h1abcd, 7'h7f});
        commit(1'b1, 5'd1, 1'b1, 4'd1);
        commit(1'b1, 5'd2, 1'b1, 4'd2);

        // WAW on scalar r5
        run_instr(enc_scalar(OP_ALU, 5'd5, 5'd0, 5'd0, 3'd0));
        run_instr(enc_scalar(OP_LOAD, 5'd5, 5'd1, 5'd1, 3'd0));
        confirm_stall(1'b1);
        run_instr(enc_scalar(OP_LOAD, 5'd5, 5'd1, 5'd1, 3'd0));
        drive_cycle(enc_scalar(OP_LOAD, 5'd5, 5'd1, 5'd1, 3'd0),
                    1'b1, 1'b0, 1'b0, '0, '0, 1'b1, 5'd5, 1'b0, '0);
        confirm_stall(1'b1);  // clear lands on this edge
        run_instr(enc_scalar(OP_LOAD, 5'd5, 5'd1, 5'd1, 3'd0));
        confirm_stall(1'b0);
        // commit and dispatch to idle r6 together
        drive_cycle(enc_scalar(OP_ALU, 5'd6, 5'd2, 5'd3, 3'd4),
                    1'b1, 1'b0, 1'b0, '0, '0, 1'b1, 5'd6, 1'b0, '0);
        run_instr(enc_scalar(OP_ALU, 5'd6, 5'd2, 5'd3, 3'd4));
        confirm_stall(1'b1);
        commit(1'b1, 5'd6, 1'b0, '0);
        commit(1'b1, 5'd5, 1'b0, '0);

        // busy units
        drive_cycle(enc_scalar(OP_ALU, 5'd7, 5'd1, 5'd2, 3'd1),
                    1'b1, 1'b0, 1'b0, 3'b001, 2'b00, 1'b0, '0, 1'b0, '0);
        confirm_stall(1'b1);
        drive_cycle(enc_matrix(OP_GEMM, 4'd5, 4'd6, 4'd7, 4'd8),
                    1'b1, 1'b0, 1'b0, 3'b000, 2'b10, 1'b0, '0, 1'b0, '0);
        confirm_stall(1'b1);
        run_instr(enc_matrix(OP_GEMM, 4'd5, 4'd6, 4'd7, 4'd8));
        commit(1'b0, '0, 1'b1, 4'd5);

        // freeze, then flush, neither may set a table entry
        drive_cycle(enc_scalar(OP_ALU, 5'd8, 5'd1, 5'd2, 3'd0),
                    1'b1, 1'b1, 1'b0, '0, '0, 1'b0, '0, 1'b0, '0);
        run_instr(enc_scalar(OP_LOAD, 5'd8, 5'd3, 5'd4, 3'd0));
        confirm_stall(1'b0);
        commit(1'b1, 5'd8, 1'b0, '0);
        drive_cycle(enc_matrix(OP_MLOAD, 4'd6, 4'd1, 4'd2, 4'd3),
                    1'b1, 1'b0, 1'b1, '0, '0, 1'b0, '0, 1'b0, '0);
        run_instr(enc_matrix(OP_GEMM, 4'd6, 4'd1, 4'd2, 4'd3));
        confirm_stall(1'b0);
        commit(1'b0, '0, 1'b1, 4'd6);

        repeat (RAND_CYCLES) begin
            random_cycle();
        end

        commit(1'b0, '0, 1'b0, '0);
        repeat (2) @(negedge CLK);
        @(posedge CLK);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hw
+incdir+test
hw/dispatch_pkg.sv
hw/reg_status_if.sv
hw/decoder.sv
hw/reg_status_table.sv
hw/dispatch_stage.sv
hw/dispatch_top.sv
test/dispatch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f flist.f --top-module dispatch_tb -o dispatch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dispatch_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
